// ==== flist.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_queue.sv
hw/pc_gen.sv
hw/rv32i_decode.sv
hw/fetch_frontend.sv
verif/fetch_frontend_checker.sv
verif/fetch_frontend_monitor.sv
verif/fetch_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/fetch_queue.sv
      - hw/pc_gen.sv
      - hw/rv32i_decode.sv
      - hw/fetch_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/fetch_frontend_checker.sv
      - verif/fetch_frontend_monitor.sv
      - verif/fetch_frontend_tb.sv

// ==== verif/fetch_frontend_tb.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_frontend_tb;

	import fetch_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int STREAM_ITEMS = 100;
	localparam int BP_ITEMS = 200;
	localparam int REDIRECTS = 8;
	localparam int PER_REDIRECT = 16;
	localparam int SWEEP_ITEMS = 256;
	localparam int TOTAL_ITEMS = STREAM_ITEMS + BP_ITEMS + REDIRECTS * PER_REDIRECT
		+ SWEEP_ITEMS;
	localparam int CYCLE_LIMIT = 20 * TOTAL_ITEMS + RESET_CYCLES;

	logic clk;
	logic rst;
	logic redirect_valid;
	logic [`XLEN-1:0] redirect_pc;
	logic imem_req;
	logic [`XLEN-1:0] imem_addr;
	logic imem_rvalid;
	logic [`XLEN-1:0] imem_rdata;
	logic dec_valid;
	logic dec_ready;
	logic [`XLEN-1:0] dec_pc;
	opcode_t dec_opcode;
	logic [4:0] dec_rd;
	logic [4:0] dec_rs1;
	logic [4:0] dec_rs2;
	logic [2:0] dec_funct3;
	logic [6:0] dec_funct7;
	logic [`XLEN-1:0] dec_imm;
	logic dec_illegal;

	// instruction memory model with one word per address/4 mod 256
	logic [`XLEN-1:0] imem [256];
	logic mem_pending;
	logic [`XLEN-1:0] mem_addr;

	int item_count;
	int err_count;
	int illegal_count;
	int cycles;
	int planted;
	int mark_items;
	int mark_errs;
	int sweep_illegal;
	int sweep_errs;
	int total_errs;
	int r;

	fetch_frontend dut0 (.*);

	fetch_frontend_monitor mon0 (.*);

	bind fetch_frontend fetch_frontend_checker checker0 (
		.clk(clk),
		.rst(rst),
		.redirect_valid(redirect_valid),
		.imem_req(imem_req),
		.imem_rvalid(imem_rvalid),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_pc(dec_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// request seen at the edge and answered in the following cycle
	always @(posedge clk) begin
		mem_pending <= (imem_req === 1'b1);
		mem_addr <= imem_addr;
	end

	always @(negedge clk) begin
		imem_rvalid = mem_pending;
		imem_rdata = mem_pending ? imem[mem_addr[9:2]] : '0;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic opcode_t pick_opcode(input int k);
		opcode_t op;
		op = op.first();
		repeat (k) begin
			op = op.next();
		end
		return op;
	endfunction

	task automatic fill_memory();
		logic [`XLEN-1:0] w;
		int i;
		for (i = 0; i < 256; i++) begin
			w = $urandom;
			w[6:0] = pick_opcode($urandom_range(9));
			// planted words with an unknown opcode or broken low bits
			if (i % 41 == 7) begin
				w[6:0] = ((i / 41) % 2 == 0) ? 7'b0001011 : {w[6:2], 2'b10};
				planted++;
			end
			imem[i] = w;
		end
	endtask

	task automatic run_items(input int n, input int ready_pct);
		int target;
		target = item_count + n;
		@(negedge clk);
		while (item_count < target) begin
			dec_ready = ($urandom_range(99) < ready_pct);
			@(negedge clk);
		end
		dec_ready = 1'b0;
	endtask

	task automatic pulse_redirect(input logic [`XLEN-1:0] target);
		@(negedge clk);
		redirect_valid = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		redirect_valid = 1'b0;
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		errs = err_count + sweep_errs + dut0.checker0.assert_fails;
		$display("test %0d %s: %0d items, %0d errors", num, name,
			item_count - mark_items, errs - mark_errs);
		mark_items = item_count;
		mark_errs = errs;
	endtask

	initial begin
		void'($urandom(24));
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		dec_ready = 1'b0;
		imem_rvalid = 1'b0;
		imem_rdata = '0;
		cycles = 0;
		planted = 0;
		sweep_errs = 0;
		mark_items = 0;
		mark_errs = 0;
		fill_memory();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// hold issue side until the first decoded word shows up
		while (!dec_valid) begin
			@(negedge clk);
		end
		report_test(1, "reset");
		run_items(STREAM_ITEMS, 100);
		report_test(2, "streaming");
		run_items(BP_ITEMS, 40);
		report_test(3, "back-pressure");

		for (r = 0; r < REDIRECTS; r++) begin
			repeat ($urandom_range(10, 2)) begin
				@(negedge clk);
				dec_ready = ($urandom_range(99) < 75);
			end
			pulse_redirect($urandom & 32'h0000_fffc);
			run_items(PER_REDIRECT, 75);
		end
		report_test(4, "redirect");

		// one pass over the whole memory including the planted words
		sweep_illegal = illegal_count;
		pulse_redirect('0);
		run_items(SWEEP_ITEMS, 100);
		if (illegal_count - sweep_illegal != planted) begin
			sweep_errs++;
			$display("error at %0t: dec_illegal count expected %0d got %0d", $time,
				planted, illegal_count - sweep_illegal);
		end
		report_test(5, "format sweep");

		total_errs = err_count + sweep_errs + dut0.checker0.assert_fails;
		$display("done: %0d items, %0d compare errors, %0d assertion failures",
			item_count, err_count + sweep_errs, dut0.checker0.assert_fails);
		if (total_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/fetch_frontend_monitor.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_frontend_monitor (
	input logic clk,
	input logic rst,
	input logic redirect_valid,
	input logic [`XLEN-1:0] redirect_pc,
	input logic imem_req,
	input logic [`XLEN-1:0] imem_addr,
	input logic dec_valid,
	input logic dec_ready,
	input logic [`XLEN-1:0] dec_pc,
	input fetch_pkg::opcode_t dec_opcode,
	input logic [4:0] dec_rd,
	input logic [4:0] dec_rs1,
	input logic [4:0] dec_rs2,
	input logic [2:0] dec_funct3,
	input logic [6:0] dec_funct7,
	input logic [`XLEN-1:0] dec_imm,
	input logic dec_illegal,
	output int item_count,
	output int err_count,
	output int illegal_count
);

	import fetch_pkg::*;

	logic [`XLEN-1:0] exp_pc;
	logic after_reset;
	logic first_req_seen;
	dec_t expd;

	// expected fields from the rv32i encoding tables
	function automatic dec_t ref_decode(input logic [`XLEN-1:0] pc,
		input logic [`XLEN-1:0] w);
		dec_t d;
		logic [11:0] i_off;
		logic [11:0] s_off;
		logic [12:0] b_off;
		logic [20:0] j_off;
		i_off = w[31:20];
		s_off = {w[31:25], w[11:7]};
		b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		d.pc = pc;
		d.opcode = opcode_t'(w[6:0]);
		d.rd = w[11:7];
		d.rs1 = w[19:15];
		d.rs2 = w[24:20];
		d.funct3 = w[14:12];
		d.funct7 = w[31:25];
		d.imm = '0;
		d.illegal = (w[1:0] != 2'b11);
		case (w[6:0])
			op_lui, op_auipc: d.imm = {w[31:12], 12'h000};
			op_jal: d.imm = $signed(j_off);
			op_jalr, op_load, op_imm: d.imm = $signed(i_off);
			op_store: d.imm = $signed(s_off);
			op_branch: d.imm = $signed(b_off);
			op_op, op_system: d.imm = '0;
			default: d.illegal = 1'b1;
		endcase
		return d;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		if (got_v !== exp_v) begin
			err_count++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			exp_pc = `RESET_PC;
			after_reset = 1'b1;
			first_req_seen = 1'b0;
			item_count = 0;
			err_count = 0;
			illegal_count = 0;
		end else begin
			if (after_reset) begin
				compare_field("dec_valid", 32'd0, 32'(dec_valid));
				compare_field("imem_req", 32'd0, 32'(imem_req));
				after_reset = 1'b0;
			end
			if (imem_req && !first_req_seen) begin
				compare_field("imem_addr", `RESET_PC, imem_addr);
				first_req_seen = 1'b1;
			end
			// accepted item carries the next pc of the current stream
			if (dec_valid && dec_ready) begin
				expd = ref_decode(exp_pc, fetch_frontend_tb.imem[exp_pc[9:2]]);
				compare_field("dec_pc", expd.pc, dec_pc);
				compare_field("dec_opcode", 32'(expd.opcode), 32'(dec_opcode));
				compare_field("dec_rd", 32'(expd.rd), 32'(dec_rd));
				compare_field("dec_rs1", 32'(expd.rs1), 32'(dec_rs1));
				compare_field("dec_rs2", 32'(expd.rs2), 32'(dec_rs2));
				compare_field("dec_funct3", 32'(expd.funct3), 32'(dec_funct3));
				compare_field("dec_funct7", 32'(expd.funct7), 32'(dec_funct7));
				compare_field("dec_imm", expd.imm, dec_imm);
				compare_field("dec_illegal", 32'(expd.illegal), 32'(dec_illegal));
				item_count++;
				if (dec_illegal) begin
					illegal_count++;
				end
				exp_pc = exp_pc + 32'd4;
			end
			// items after the redirect cycle start at the target
			if (redirect_valid) begin
				exp_pc = redirect_pc;
			end
		end
	end

endmodule

// ==== verif/fetch_frontend_checker.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_frontend_checker (
	input logic clk,
	input logic rst,
	input logic redirect_valid,
	input logic imem_req,
	input logic imem_rvalid,
	input logic dec_valid,
	input logic dec_ready,
	input logic [`XLEN-1:0] dec_pc
);

	// count of failed assertions
	int assert_fails = 0;

	no_req_in_redirect: assert property (@(posedge clk) disable iff (rst)
		redirect_valid |-> !imem_req)
		else begin
			$error("imem_req high in a redirect cycle");
			assert_fails++;
		end

	idle_after_reset: assert property (@(posedge clk) rst |=> !dec_valid)
		else begin
			$error("dec_valid high right after reset");
			assert_fails++;
		end

	// memory answers exactly one cycle after each request
	rvalid_follows_req: assert property (@(posedge clk) disable iff (rst)
		imem_rvalid == $past(imem_req))
		else begin
			$error("imem_rvalid not one cycle after imem_req");
			assert_fails++;
		end

	head_held: assert property (@(posedge clk) disable iff (rst)
		(dec_valid && !dec_ready && !redirect_valid) |=> (dec_valid && $stable(dec_pc)))
		else begin
			$error("dec_pc changed while stalled");
			assert_fails++;
		end

endmodule

// ==== hw/fetch_frontend.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_frontend (
	input logic clk,
	input logic rst,
	input logic redirect_valid,
	input logic [`XLEN-1:0] redirect_pc,
	output logic imem_req,
	output logic [`XLEN-1:0] imem_addr,
	input logic imem_rvalid,
	input logic [`XLEN-1:0] imem_rdata,
	output logic dec_valid,
	input logic dec_ready,
	output logic [`XLEN-1:0] dec_pc,
	output fetch_pkg::opcode_t dec_opcode,
	output logic [4:0] dec_rd,
	output logic [4:0] dec_rs1,
	output logic [4:0] dec_rs2,
	output logic [2:0] dec_funct3,
	output logic [6:0] dec_funct7,
	output logic [`XLEN-1:0] dec_imm,
	output logic dec_illegal
);

	import fetch_pkg::*;

	localparam int FQ_CW = $clog2(`FQ_DEPTH + 1);

	pci_t fq_wdata;
	pci_t fq_rdata;
	logic fq_push;
	logic fq_pop;
	logic fq_empty;
	logic [FQ_CW-1:0] fq_count;

	dec_t dq_wdata;
	dec_t dq_rdata;
	logic dq_push;
	logic dq_pop;
	logic dq_empty;
	logic dq_full;

	pc_gen pc_gen0 (
		.clk(clk),
		.rst(rst),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.fq_count(fq_count),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rvalid(imem_rvalid),
		.imem_rdata(imem_rdata),
		.fq_push(fq_push),
		.fq_wdata(fq_wdata)
	);

	// pc_gen paces requests by count so this queue never overflows
	fetch_queue #(.payload_t(pci_t), .depth(`FQ_DEPTH)) fq0 (
		.clk(clk),
		.rst(rst),
		.flush(redirect_valid),
		.push(fq_push),
		.pop(fq_pop),
		.wdata(fq_wdata),
		.rdata(fq_rdata),
		.empty(fq_empty),
		.full(),
		.count(fq_count)
	);

	rv32i_decode decode0 (
		.fq_rdata(fq_rdata),
		.fq_empty(fq_empty),
		.fq_pop(fq_pop),
		.dq_full(dq_full),
		.dq_push(dq_push),
		.dq_wdata(dq_wdata)
	);

	fetch_queue #(.payload_t(dec_t), .depth(`DQ_DEPTH)) dq0 (
		.clk(clk),
		.rst(rst),
		.flush(redirect_valid),
		.push(dq_push),
		.pop(dq_pop),
		.wdata(dq_wdata),
		.rdata(dq_rdata),
		.empty(dq_empty),
		.full(dq_full),
		.count()
	);

	// issue handshake on the decoded queue head
	assign dec_valid = !dq_empty;
	assign dq_pop = dec_valid && dec_ready;

	assign dec_pc = dq_rdata.pc;
	assign dec_opcode = dq_rdata.opcode;
	assign dec_rd = dq_rdata.rd;
	assign dec_rs1 = dq_rdata.rs1;
	assign dec_rs2 = dq_rdata.rs2;
	assign dec_funct3 = dq_rdata.funct3;
	assign dec_funct7 = dq_rdata.funct7;
	assign dec_imm = dq_rdata.imm;
	assign dec_illegal = dq_rdata.illegal;

endmodule

// ==== hw/rv32i_decode.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module rv32i_decode (
	input fetch_pkg::pci_t fq_rdata,
	input logic fq_empty,
	output logic fq_pop,
	input logic dq_full,
	output logic dq_push,
	output fetch_pkg::dec_t dq_wdata
);

	import fetch_pkg::*;

	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] imm;
	logic known_op;
	logic low_bits_ok;

	assign instr = fq_rdata.instr;

	// one instruction moves whenever both queues allow it
	assign fq_pop = !fq_empty && !dq_full;
	assign dq_push = fq_pop;

	assign low_bits_ok = (instr[1:0] == 2'b11);

	// immediate by format
	always_comb begin
		known_op = 1'b1;
		imm = '0;
		case (instr[6:0])
			op_lui, op_auipc: begin
				imm = {instr[31:12], 12'b0};
			end
			op_jal: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			op_jalr, op_load, op_imm: begin
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			op_store: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			op_branch: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			op_op, op_system: begin
				// r-type and system carry no immediate
				imm = '0;
			end
			default: begin
				known_op = 1'b0;
			end
		endcase
	end

	// fixed field positions and an illegal word still passes through
	always_comb begin
		dq_wdata.pc = fq_rdata.pc;
		dq_wdata.opcode = opcode_t'(instr[6:0]);
		dq_wdata.rd = instr[11:7];
		dq_wdata.rs1 = instr[19:15];
		dq_wdata.rs2 = instr[24:20];
		dq_wdata.funct3 = instr[14:12];
		dq_wdata.funct7 = instr[31:25];
		dq_wdata.imm = imm;
		dq_wdata.illegal = !known_op || !low_bits_ok;
	end

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/100ps
`include "fetch_consts.svh"

module pc_gen (
	input logic clk,
	input logic rst,
	input logic redirect_valid,
	input logic [`XLEN-1:0] redirect_pc,
	input logic [$clog2(`FQ_DEPTH+1)-1:0] fq_count,
	output logic imem_req,
	output logic [`XLEN-1:0] imem_addr,
	input logic imem_rvalid,
	input logic [`XLEN-1:0] imem_rdata,
	output logic fq_push,
	output fetch_pkg::pci_t fq_wdata
);

	localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

	logic [`XLEN-1:0] fetch_pc;
	logic [`XLEN-1:0] req_pc;
	logic [CNT_W:0] occupancy;
	logic has_space;
	logic live;

	// queue entries plus the response landing this cycle
	assign occupancy = {1'b0, fq_count} + (CNT_W+1)'(imem_rvalid);
	assign has_space = (occupancy < (CNT_W+1)'(`FQ_DEPTH));

	// no request while the queues are being flushed
	assign imem_req = live && has_space && !redirect_valid;
	assign imem_addr = fetch_pc;

	// memory answers one cycle later while req_pc still holds that address
	assign fq_push = imem_rvalid;
	assign fq_wdata = '{pc: req_pc, instr: imem_rdata};

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= `RESET_PC;
			live <= 1'b0;
		end else begin
			live <= 1'b1;
			if (redirect_valid) begin
				fetch_pc <= redirect_pc;
			end else if (imem_req) begin
				fetch_pc <= fetch_pc + `XLEN'(4);
			end
		end
	end

	// tag of the outstanding request
	always_ff @(posedge clk) begin
		if (imem_req) begin
			req_pc <= fetch_pc;
		end
	end

endmodule

// ==== hw/fetch_queue.sv ====
`timescale 1ns/100ps

module fetch_queue #(
	parameter type payload_t = logic [31:0],
	parameter int depth = 8
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic push,
	input logic pop,
	input payload_t wdata,
	output payload_t rdata,
	output logic empty,
	output logic full,
	output logic [$clog2(depth+1)-1:0] count
);

	localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
	localparam int CNT_W = $clog2(depth + 1);

	payload_t mem [depth];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic do_push;
	logic do_pop;

	// pointer increment that also works for non power of two depths
	function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(depth - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	assign empty = (count == '0);
	assign full = (count == CNT_W'(depth));

	// guard against a producer or consumer breaking the protocol
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// head entry is visible one cycle after its push
	assign rdata = mem[head];

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				tail <= wrap_inc(tail);
			end
			if (do_pop) begin
				head <= wrap_inc(head);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	// storage array
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail] <= wdata;
		end
	end

endmodule

// ==== hw/fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

	// rv32i major opcodes with the low two bits always 2'b11
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_op     = 7'b0110011,
		op_system = 7'b1110011
	} opcode_t;

	// raw word tagged with the pc it was fetched from
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} pci_t;

	// decoded fields handed to the issue stage
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		opcode_t opcode;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic [`XLEN-1:0] imm;
		logic illegal;
	} dec_t;

endpackage

// ==== hw/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// width of pc and instruction word
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0100

// fetch queue sits between pc_gen and decode
`define FQ_DEPTH 8

// decoded queue feeds the issue stage
`define DQ_DEPTH 4

`endif
